// ==== vlog.f ====
+incdir+source
source/icache_pkg.sv
source/icache_line_store.sv
source/icache_valid_ram.sv
source/icache_fetch_stage.sv
source/icache_compare_stage.sv
source/icache_refill.sv
source/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = icache_tb
FILELIST = vlog.f
BUILD    = obj_dir

SIM_BIN  = $(BUILD)/V$(TOP)
SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(BUILD)

// ==== test/icache_tb.sv ====
//********************************************************************
// testbench for the instruction cache with word aligned fetches only
// hit or miss predicted from a tag model kept in issue order
// outputs sampled on the falling edge and inputs driven 1 ns after rise
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int   hang_limit  = 300;
    localparam tag_t tag_home    = 23'h000123;
    localparam tag_t tag_alt     = 23'h0004d2;
    localparam tag_t tag_evict_a = 23'h07aa01;
    localparam tag_t tag_evict_b = 23'h07aa02;

    logic  clk;
    logic  arst_n;
    logic  req_valid;
    addr_t req_addr;
    logic  flush;
    logic  mem_resp_valid;
    line_t mem_resp_line;
    logic  busy;
    logic  resp_valid;
    addr_t resp_addr;
    word_t resp_data;
    logic  mem_req;
    addr_t mem_addr;

    // reference tag model
    tag_t                    model_tag [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] model_valid;

    // expected responses in issue order
    addr_t exp_addr  [$];
    int    exp_cycle [$];
    bit    exp_exact [$];
    bit    exp_miss  [$];
    // expected line requests
    addr_t miss_lines [$];

    int cycle;
    int errors;
    int pending_misses;
    int predicted_misses;
    int mem_req_count;
    bit fill_outstanding;
    bit hung;
    int tests_run;
    int tests_failed;
    int test_errors_start;

    icache_top UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_addr       (req_addr),
        .flush          (flush),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line),
        .busy           (busy),
        .resp_valid     (resp_valid),
        .resp_addr      (resp_addr),
        .resp_data      (resp_data),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr)
    );

    icache_mem_model u_mem (
        .clk            (clk),
        .arst_n         (arst_n),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // memory word = its own aligned byte address xor A5A5_0000
    function automatic word_t expected_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic addr_t make_addr(input tag_t tag, input index_t index,
                                        input logic [1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // wait for busy low, predict the outcome, then pulse req_valid
    task automatic fetch(input addr_t addr);
        index_t idx;
        tag_t   tag;
        bit     hit;
        int     guard;
        idx   = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        tag   = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        guard = 0;
        while (busy && !hung) begin
            next_cycle();
            guard++;
            if (guard > hang_limit) begin
                $display("timeout: cache stayed busy for %0d cycles", guard);
                hung = 1'b1;
            end
        end
        if (!hung) begin
            hit = model_valid[idx] && (model_tag[idx] == tag);
            if (!hit) begin
                // a miss refills the set so later fetches see the new tag
                miss_lines.push_back({addr[31:4], 4'b0000});
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
                pending_misses++;
                predicted_misses++;
            end
            exp_addr.push_back(addr);
            exp_cycle.push_back(cycle);
            exp_exact.push_back(hit && (pending_misses == 0));
            exp_miss.push_back(!hit);
            req_valid = 1'b1;
            req_addr  = addr;
            next_cycle();
            req_valid = 1'b0;
        end
    endtask

    // let every issued fetch respond and every fill finish
    task automatic drain();
        int guard;
        guard = 0;
        while (!hung && (exp_addr.size() != 0 || busy || fill_outstanding)) begin
            next_cycle();
            guard++;
            if (guard > hang_limit) begin
                $display("timeout: %0d responses still missing after %0d cycles",
                         exp_addr.size(), guard);
                hung = 1'b1;
            end
        end
        repeat (2) next_cycle();
    endtask

    task automatic flush_cache();
        drain();
        flush       = 1'b1;
        model_valid = '0;
        next_cycle();
        flush = 1'b0;
    endtask

    task automatic end_test(input string name);
        drain();
        assert (mem_req_count == predicted_misses) else
            report_error($sformatf("%0d line requests seen, %0d misses predicted",
                                   mem_req_count, predicted_misses));
        assert (miss_lines.size() == 0) else
            report_error("predicted line request never issued");
        tests_run++;
        if (hung || errors != test_errors_start) begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - test_errors_start);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        test_errors_start = errors;
    endtask

    // response and memory side checks
    always @(negedge clk) begin
        if (resp_valid) begin
            assert (exp_addr.size() != 0) else
                report_error("response with no fetch outstanding");
            if (exp_addr.size() != 0) begin
                assert (resp_addr == exp_addr[0]) else
                    report_error($sformatf("resp_addr %h, expected %h",
                                           resp_addr, exp_addr[0]));
                assert (resp_data == expected_word(exp_addr[0])) else
                    report_error($sformatf("resp_data %h for %h, expected %h", resp_data,
                                           exp_addr[0], expected_word(exp_addr[0])));
                // undisturbed hit has fixed latency
                assert (!exp_exact[0] || (cycle - exp_cycle[0] == 3)) else
                    report_error($sformatf("hit on %h took %0d cycles, expected 3",
                                           exp_addr[0], cycle - exp_cycle[0]));
                if (exp_miss[0]) begin
                    pending_misses--;
                end
                void'(exp_addr.pop_front());
                void'(exp_cycle.pop_front());
                void'(exp_exact.pop_front());
                void'(exp_miss.pop_front());
            end
        end
        if (mem_req) begin
            mem_req_count++;
            assert (!fill_outstanding) else
                report_error("second line request while a fill is outstanding");
            assert (miss_lines.size() != 0) else
                report_error($sformatf("unexpected line request for %h", mem_addr));
            if (miss_lines.size() != 0) begin
                assert (mem_addr == miss_lines[0]) else
                    report_error($sformatf("mem_addr %h, expected %h",
                                           mem_addr, miss_lines[0]));
                void'(miss_lines.pop_front());
            end
            fill_outstanding = 1'b1;
        end
        // busy from the miss until the fill returns
        assert (!fill_outstanding || busy) else
            report_error("busy dropped while a line fill was outstanding");
        if (mem_resp_valid) begin
            fill_outstanding = 1'b0;
        end
        assert (!busy || pending_misses > 0) else
            report_error("busy high with no miss in flight");
    end

    initial begin
        addr_t a;
        int    i;
        void'($urandom(96559));
        arst_n            = 1'b0;
        req_valid         = 1'b0;
        req_addr          = '0;
        flush             = 1'b0;
        cycle             = 0;
        errors            = 0;
        pending_misses    = 0;
        predicted_misses  = 0;
        mem_req_count     = 0;
        fill_outstanding  = 1'b0;
        hung              = 1'b0;
        tests_run         = 0;
        tests_failed      = 0;
        test_errors_start = 0;
        model_valid       = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // idle outputs then cold misses to five sets
        for (i = 0; i < 4; i++) begin
            assert (!busy && !resp_valid && !mem_req) else
                report_error("outputs not idle after reset");
            next_cycle();
        end
        for (i = 0; i < 5; i++) begin
            fetch(make_addr(tag_home, index_t'(4 * i), 2'(i)));
        end
        end_test("cold misses");

        // isolated hits over all four word offsets
        for (i = 0; i < 4; i++) begin
            fetch(make_addr(tag_home, 5'd4, 2'(i)));
            drain();
        end
        end_test("single hits");

        // back-to-back hits stream one per cycle
        for (i = 0; i < 12; i++) begin
            fetch(make_addr(tag_home, index_t'(4 * (i % 5)), 2'(i)));
        end
        end_test("hit burst");

        // miss with a second fetch right behind it
        fetch(make_addr(tag_alt, 5'd20, 2'd2));
        fetch(make_addr(tag_home, 5'd4, 2'd3));
        fetch(make_addr(tag_alt, 5'd21, 2'd0));
        fetch(make_addr(tag_alt, 5'd21, 2'd3));
        end_test("miss then fetch");

        // same set with two tags so every fetch evicts
        for (i = 0; i < 6; i++) begin
            a = make_addr((i % 2 == 0) ? tag_evict_a : tag_evict_b, 5'd9, 2'(i));
            fetch(a);
        end
        end_test("eviction");

        // flush forces a refill before a random mix
        fetch(make_addr(tag_home, 5'd0, 2'd2));
        flush_cache();
        fetch(make_addr(tag_home, 5'd0, 2'd2));
        for (i = 0; i < 200; i++) begin
            if (i == 100) begin
                flush_cache();
            end
            a = make_addr(tag_t'(32'h100 + $urandom_range(2, 0)),
                          index_t'($urandom_range(7, 0)), 2'($urandom_range(3, 0)));
            fetch(a);
            if ($urandom_range(3, 0) == 0) begin
                next_cycle();
            end
        end
        end_test("flush and random mix");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (hung || errors != 0) begin
            $display("Simulation FAILED");
        end else begin
            $display("Simulation PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/icache_mem_model.sv ====
//********************************************************************
// backing memory for the cache testbench
// takes one line request at a time, answers after 3 to 10 cycles
// word k of line A reads back as (A + 4k) xor A5A5_0000
// a second request while one is pending is ignored here
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_mem_model
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  mem_req,
    input  addr_t mem_addr,
    output logic  mem_resp_valid,
    output line_t mem_resp_line
);

    // latency window in cycles, counted from the mem_req cycle
    localparam int min_latency = 3;
    localparam int max_latency = 10;

    // every word carries its own byte address
    function automatic line_t build_line(input addr_t line_addr);
        line_t fill;
        int    k;
        fill = '0;
        for (k = 0; k < `ICACHE_LINE_W / `ICACHE_WORD_W; k++) begin
            fill[k*`ICACHE_WORD_W +: `ICACHE_WORD_W] =
                (line_addr + addr_t'(4 * k)) ^ 32'hA5A5_0000;
        end
        return fill;
    endfunction

    initial begin
        addr_t held_addr;
        int    wait_cnt;
        bit    pending;
        mem_resp_valid = 1'b0;
        mem_resp_line  = '0;
        held_addr      = '0;
        wait_cnt       = 0;
        pending        = 1'b0;
        forever begin
            // outputs move just after the edge like all other stimulus
            @(posedge clk);
            #1;
            mem_resp_valid = 1'b0;
            if (!arst_n) begin
                pending = 1'b0;
            end else if (pending) begin
                if (wait_cnt == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_line  = build_line(held_addr);
                    pending        = 1'b0;
                end else begin
                    wait_cnt--;
                end
            end else if (mem_req) begin
                held_addr = mem_addr;
                // one cycle already spent, answer lands in cycle req + latency
                wait_cnt  = int'($urandom_range(max_latency, min_latency)) - 1;
                pending   = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_top.sv ====
//********************************************************************
// instruction cache top, 32 sets direct mapped, read only
// hit latency 3 cycles, requester must not fetch while busy
// flush only while idle with no response pending
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  flush,
    input  logic  mem_resp_valid,
    input  line_t mem_resp_line,
    output logic  busy,
    output logic  resp_valid,
    output addr_t resp_addr,
    output word_t resp_data,
    output logic  mem_req,
    output addr_t mem_addr
);

    // stage 1 to stage 2
    logic   s1_valid;
    addr_t  s1_addr;
    logic   stall;
    addr_t  miss_addr;

    // array read side
    index_t rd_index;
    tag_t   rd_tag;
    line_t  rd_line;
    logic   rd_valid;

    // array write side, driven by the refill FSM
    logic   wr_en;
    index_t wr_index;
    tag_t   wr_tag;
    line_t  wr_line;

    // a pending miss is the only reason to push back
    assign busy = stall;

    icache_fetch_stage u_fetch (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .stall     (stall),
        .s1_valid  (s1_valid),
        .s1_addr   (s1_addr)
    );

    icache_compare_stage u_compare (
        .clk        (clk),
        .arst_n     (arst_n),
        .s1_valid   (s1_valid),
        .s1_addr    (s1_addr),
        .rd_tag     (rd_tag),
        .rd_line    (rd_line),
        .rd_valid   (rd_valid),
        .rd_index   (rd_index),
        .stall      (stall),
        .miss_addr  (miss_addr),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_data  (resp_data)
    );

    icache_line_store u_lines (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_tag   (wr_tag),
        .wr_line  (wr_line),
        .rd_tag   (rd_tag),
        .rd_line  (rd_line)
    );

    icache_valid_ram u_valid (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_index (rd_index),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .flush    (flush),
        .rd_valid (rd_valid)
    );

    icache_refill u_refill (
        .clk            (clk),
        .arst_n         (arst_n),
        .stall          (stall),
        .miss_addr      (miss_addr),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line),
        .wr_en          (wr_en),
        .wr_index       (wr_index),
        .wr_tag         (wr_tag),
        .wr_line        (wr_line)
    );

endmodule

`default_nettype wire

// ==== source/icache_refill.sv ====
//********************************************************************
// miss handler, one line request outstanding at a time
// mem_req is a one cycle pulse, memory may answer after any delay
// line, tag and valid are written in the cycle of mem_resp_valid
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_refill
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   stall,
    input  addr_t  miss_addr,
    output logic   mem_req,
    output addr_t  mem_addr,
    input  logic   mem_resp_valid,
    input  line_t  mem_resp_line,
    output logic   wr_en,
    output index_t wr_index,
    output tag_t   wr_tag,
    output line_t  wr_line
);

    refill_state_e state_q;
    refill_state_e state_d;
    addr_t         line_addr_q;

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            REFILL_IDLE: begin
                if (stall) begin
                    state_d = REFILL_ASK;
                end
            end
            REFILL_ASK: begin
                state_d = REFILL_WAIT;
            end
            REFILL_WAIT: begin
                if (mem_resp_valid) begin
                    state_d = REFILL_IDLE;
                end
            end
            default: begin
                state_d = REFILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= REFILL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // line aligned miss address, captured when the miss shows up
    always_ff @(posedge clk) begin
        if (state_q == REFILL_IDLE && stall) begin
            line_addr_q <= {miss_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                            {`ICACHE_OFFSET_W{1'b0}}};
        end
    end

    // request pulse lasts exactly the ASK cycle
    assign mem_req  = (state_q == REFILL_ASK);
    assign mem_addr = line_addr_q;

    // array write straight from the returning line
    assign wr_en    = (state_q == REFILL_WAIT) && mem_resp_valid;
    assign wr_index = line_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign wr_tag   = line_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign wr_line  = mem_resp_line;

endmodule

`default_nettype wire

// ==== source/icache_compare_stage.sv ====
//********************************************************************
// stage 2, tag compare and word select
// a miss raises stall combinationally and holds the entry until
// the refill makes the arrays report a hit
// response is registered, one cycle after stage entry
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_compare_stage
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   s1_valid,
    input  addr_t  s1_addr,
    input  tag_t   rd_tag,
    input  line_t  rd_line,
    input  logic   rd_valid,
    output index_t rd_index,
    output logic   stall,
    output addr_t  miss_addr,
    output logic   resp_valid,
    output addr_t  resp_addr,
    output word_t  resp_data
);

    logic  s2_valid;
    addr_t s2_addr;
    tag_t  s2_tag;
    logic  hit;
    logic [`ICACHE_OFFSET_W-3:0] word_sel;

    // stage 2 entry, frozen while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s2_addr <= s1_addr;
        end
    end

    // address fields of the held entry
    assign s2_tag   = s2_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign rd_index = s2_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign word_sel = s2_addr[`ICACHE_OFFSET_W-1:2];

    // set must be valid and hold the same tag
    assign hit   = s2_valid && rd_valid && (rd_tag == s2_tag);
    assign stall = s2_valid && !hit;

    // refill takes the full address, aligns it itself
    assign miss_addr = s2_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= hit;
        end
    end

    // response payload, only meaningful with resp_valid
    always_ff @(posedge clk) begin
        if (hit) begin
            resp_addr <= s2_addr;
            resp_data <= rd_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_fetch_stage.sv ====
//********************************************************************
// stage 1 register of the lookup pipeline
// input is dropped while stall is high, requester must watch busy
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

module icache_fetch_stage
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  req_valid,
    input  addr_t req_addr,
    input  logic  stall,
    output logic  s1_valid,
    output addr_t s1_addr
);

    // valid bit carries control, needs reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= req_valid;
        end
    end

    // address is payload only
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_addr <= req_addr;
        end
    end

endmodule

`default_nettype wire

// ==== source/icache_valid_ram.sv ====
//********************************************************************
// one valid flag per set, cleared by reset and by flush
// flush takes priority over a write in the same cycle
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_valid_ram
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  index_t rd_index,
    input  logic   wr_en,
    input  index_t wr_index,
    input  logic   flush,
    output logic   rd_valid
);

    logic [`ICACHE_SETS-1:0] valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            // invalidate every set at once
            valid_q <= '0;
        end else if (wr_en) begin
            // refill completes the set
            valid_q[wr_index] <= 1'b1;
        end
    end

    // combinational lookup for the compare stage
    assign rd_valid = valid_q[rd_index];

endmodule

`default_nettype wire

// ==== source/icache_line_store.sv ====
//********************************************************************
// data and tag storage, one entry per set, no reset
// read is combinational, write lands at the rising edge
// contents are meaningless until the valid bit of the set is set
//********************************************************************
`timescale 1ns/10ps
`default_nettype none

`include "icache_defs.svh"

module icache_line_store
    import icache_pkg::*;
(
    input  logic   clk,
    input  index_t rd_index,
    input  logic   wr_en,
    input  index_t wr_index,
    input  tag_t   wr_tag,
    input  line_t  wr_line,
    output tag_t   rd_tag,
    output line_t  rd_line
);

    // line data, 16 bytes per set
    line_t data_mem [`ICACHE_SETS];

    // tag of the line held in each set
    tag_t tag_mem [`ICACHE_SETS];

    // data and tag always written together
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_index] <= wr_line;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    // async read, old contents seen in the write cycle
    assign rd_line = data_mem[rd_index];
    assign rd_tag  = tag_mem[rd_index];

endmodule

`default_nettype wire

// ==== source/icache_pkg.sv ====
//********************************************************************
// field types shared by the cache blocks
// widths come from the defs header, refill FSM encoding lives here
//********************************************************************
`default_nettype none

`include "icache_defs.svh"

package icache_pkg;

    // byte address of a fetch
    typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
    // upper address bits stored per set
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    // word k sits at bits 32k+31 .. 32k
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;
    typedef logic [`ICACHE_WORD_W-1:0]  word_t;

    // refill controller states
    typedef enum logic [1:0] {
        REFILL_IDLE,
        REFILL_ASK,
        REFILL_WAIT
    } refill_state_e;

endpackage

`default_nettype wire

// ==== source/icache_defs.svh ====
//********************************************************************
// geometry of the direct mapped instruction cache
// tag + index + offset must add up to the address width
// line width is 4 words, offset counts bytes within a line
//********************************************************************
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// number of sets, one line per set
`define ICACHE_SETS 32

// address split
`define ICACHE_ADDR_W   32
`define ICACHE_TAG_W    23
`define ICACHE_INDEX_W  5
`define ICACHE_OFFSET_W 4

// payload widths
`define ICACHE_LINE_W 128
`define ICACHE_WORD_W 32

`endif
